//--- bench/crc_tlv_model.svh
// Reference model for the TLV CRC stage testbench, included in the testbench module.
// model_accept takes each word read from the input FIFO and queues the expected
// output FIFO word, engine port word or status strobe.

`ifndef CRC_TLV_MODEL_SVH
`define CRC_TLV_MODEL_SVH

logic [68:0] exp_ob[$];   // type, sot, eot, data
logic [73:0] exp_eng[$];  // init, sof, vbytes, data
logic        exp_stat[$]; // High for a failed check
logic [crc_tlv_pkg::WORD_NUM_W-1:0] m_num;
crc_tlv_pkg::crc_kind_e m_kind;
logic m_fail;
int m_good;
int m_bad;

function automatic logic [63:0] crc_select(input crc_tlv_pkg::crc_kind_e kind,
                                           input logic [63:0] c64, input logic [31:0] c32);
  if (kind == crc_tlv_pkg::KIND_CRC32) return {32'h0, c32};
  return c64;
endfunction

task automatic model_reset();
  m_num = '0;
  m_kind = crc_tlv_pkg::KIND_CRC64;
  m_fail = 1'b0;
  m_good = 0;
  m_bad = 0;
  exp_ob.delete();
  exp_eng.delete();
  exp_stat.delete();
endtask

task automatic model_accept(input logic [76:0] w);
  crc_tlv_pkg::tlv_type_e typ;
  logic [63:0] data;
  logic [63:0] out;
  logic [63:0] sel;
  typ = crc_tlv_pkg::tlv_type_e'(w[76:74]);
  data = w[63:0];
  out = data;
  sel = crc_select(m_kind, crc64_value, crc32_value);
  if (w[73]) m_num = '0;
  else if (m_num != '1) m_num = m_num + 8'd1;
  case (typ)
    crc_tlv_pkg::TLV_CMD: if (m_num == crc_tlv_pkg::CMD_KIND_WORD)
      m_kind = crc_tlv_pkg::crc_kind_e'(data[crc_tlv_pkg::CMD_KIND_BIT]);
    crc_tlv_pkg::TLV_DATA:
      exp_eng.push_back({w[73], m_num == 8'd1, w[73] ? 8'h00 : w[71:64], data});
    crc_tlv_pkg::TLV_FTR: begin
      if (m_num == crc_tlv_pkg::FTR_CRC_WORD && crc_mode == crc_tlv_pkg::CRC_GEN) out = sel;
      if (m_num == crc_tlv_pkg::FTR_CRC_WORD && crc_mode == crc_tlv_pkg::CRC_CHK)
        m_fail = (data != sel);
      if (w[72] && crc_mode == crc_tlv_pkg::CRC_CHK) begin
        // Error field only patched when still clear
        if (m_fail && data[crc_tlv_pkg::ERR_CODE_W-1:0] == '0)
          out[crc_tlv_pkg::ERR_CODE_W-1:0] = crc_tlv_pkg::CRC_ERR_CODE;
        exp_stat.push_back(m_fail);
        if (m_fail) m_bad++;
        else m_good++;
        m_fail = 1'b0;
      end
      exp_ob.push_back({typ, w[73], w[72], out});
    end
    default: ;
  endcase
endtask

`endif

//--- bench/crc_tlv_stage_tb.sv
// Testbench for the TLV CRC stream stage.
// Random command, data and footer frames in off, generate and check modes,
// under random input empty and output almost full, checked against a model.

`default_nettype none

module crc_tlv_stage_tb;

  localparam int FRAMES = 40; // Frames per test

  logic clk = 1'b0;
  logic rst_n;
  logic ib_sot = 1'b0, ib_eot = 1'b0, ib_empty = 1'b1, ob_afull = 1'b0;
  logic ib_rd, ob_wr, ob_sot, ob_eot, eng_valid, eng_init, eng_sof, chk_good, chk_err;
  crc_tlv_pkg::tlv_type_e ib_type = crc_tlv_pkg::TLV_OTHER;
  crc_tlv_pkg::tlv_type_e ob_type;
  crc_tlv_pkg::crc_mode_e crc_mode;
  logic [crc_tlv_pkg::DATA_W-1:0] ib_tdata = '0, ob_tdata, eng_data, crc64_value;
  logic [crc_tlv_pkg::STRB_W-1:0] ib_tstrb = '0, eng_vbytes;
  logic [31:0] crc32_value;
  logic [crc_tlv_pkg::CNT_W-1:0] good_count, err_count;

  logic [76:0] in_q[$];  // Input FIFO words as type/sot/eot/strb/data
  logic [76:0] stim[$];
  int test_words[4];
  crc_tlv_pkg::crc_mode_e test_mode[4];
  logic [63:0] test_crc64[4];
  logic [31:0] test_crc32[4];
  int errors = 0;
  int checks = 0;
  int cycles = 0;
  int limit = 0;

  `include "crc_tlv_model.svh"

  crc_tlv_stage dut (.*);

  always #10 clk = ~clk;

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] t=%0t %s: expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("Error at t=%0t: %s", $time, what);
  endtask

  function automatic logic [7:0] rand8();
    logic [31:0] r;
    r = $urandom;
    return r[7:0];
  endfunction

  task automatic add_word(input crc_tlv_pkg::tlv_type_e typ, input logic sot, input logic eot,
                          input logic [63:0] data, input int t);
    stim.push_back({typ, sot, eot, rand8(), data});
    test_words[t]++;
  endtask

  task automatic build_test(input int t, input logic bad);
    crc_tlv_pkg::crc_kind_e kind;
    logic [63:0] data;
    int pick;
    int len;
    kind = crc_tlv_pkg::KIND_CRC64;
    test_words[t] = 0;
    for (int f = 0; f < FRAMES; f++) begin
      pick = $urandom_range(9, 0);
      if (pick < 2) begin
        kind = crc_tlv_pkg::crc_kind_e'(pick[0]);
        data = {$urandom, $urandom};
        data[crc_tlv_pkg::CMD_KIND_BIT] = kind;
        add_word(crc_tlv_pkg::TLV_CMD, 1'b1, 1'b0, {$urandom, $urandom}, t);
        add_word(crc_tlv_pkg::TLV_CMD, 1'b0, 1'b1, data, t);
      end else if (pick < 6) begin
        len = $urandom_range(6, 2);
        for (int i = 0; i < len; i++)
          add_word(crc_tlv_pkg::TLV_DATA, i == 0, i == len - 1, {$urandom, $urandom}, t);
      end else begin
        for (int i = 0; i < 8; i++) begin
          data = {$urandom, $urandom};
          if (i == 5 && test_mode[t] == crc_tlv_pkg::CRC_CHK) begin
            data = crc_select(kind, test_crc64[t], test_crc32[t]);
            if (bad && $urandom_range(1, 0) == 1) data[63:32] = ~data[63:32];
          end
          if (i == 7 && $urandom_range(1, 0) == 1) data[7:0] = 8'h00; // Clear error field
          add_word(crc_tlv_pkg::TLV_FTR, i == 0, i == 7, data, t);
        end
      end
    end
  endtask

  // Input FIFO and back-pressure
  always @(posedge clk) begin
    logic [31:0] r;
    r = $urandom;
    if (ib_rd && (ib_empty || ob_afull)) report_error("ib_rd high while FIFO empty or afull");
    if (rst_n && ib_rd) model_accept(in_q.pop_front());
    ob_afull <= (r[1:0] == 2'b00);
    if (in_q.size() > 0 && r[3:2] != 2'b00) begin
      ib_empty <= 1'b0;
      ib_type  <= crc_tlv_pkg::tlv_type_e'(in_q[0][76:74]);
      ib_sot   <= in_q[0][73];
      ib_eot   <= in_q[0][72];
      ib_tstrb <= in_q[0][71:64];
      ib_tdata <= in_q[0][63:0];
    end else begin
      ib_empty <= 1'b1;
    end
  end

  always @(posedge clk) begin
    logic [73:0] e;
    logic [68:0] o;
    logic b;
    if (rst_n && (eng_valid || eng_init)) begin
      if (exp_eng.size() == 0) report_error("engine port word with none expected");
      else begin
        e = exp_eng.pop_front();
        check_value("eng_valid", 64'(!e[73]), 64'(eng_valid));
        check_value("eng_init", 64'(e[73]), 64'(eng_init));
        check_value("eng_sof", 64'(e[72]), 64'(eng_sof));
        check_value("eng_vbytes", 64'(e[71:64]), 64'(eng_vbytes));
        check_value("eng_data", e[63:0], eng_data);
      end
    end
    if (rst_n && ob_wr) begin
      if (exp_ob.size() == 0) report_error("output FIFO write with none expected");
      else begin
        o = exp_ob.pop_front();
        check_value("ob_type", 64'(o[68:66]), 64'(ob_type));
        check_value("ob_sot", 64'(o[65]), 64'(ob_sot));
        check_value("ob_eot", 64'(o[64]), 64'(ob_eot));
        check_value("ob_tdata", o[63:0], ob_tdata);
      end
    end
    if (rst_n && (chk_good || chk_err)) begin
      if (exp_stat.size() == 0) report_error("status pulse with no checked frame");
      else begin
        b = exp_stat.pop_front();
        check_value("chk_err", 64'(b), 64'(chk_err));
        check_value("chk_good", 64'(!b), 64'(chk_good));
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Run timed out after %0d cycles with traffic still pending", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  task automatic run_test(input int t, input string name);
    int errs_before;
    errs_before = errors;
    @(posedge clk);
    crc_mode    <= test_mode[t];
    crc64_value <= test_crc64[t];
    crc32_value <= test_crc32[t];
    rst_n       <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    model_reset();
    for (int i = 0; i < test_words[t]; i++) in_q.push_back(stim.pop_front());
    @(posedge clk);
    while (in_q.size() > 0 || exp_ob.size() > 0 || exp_eng.size() > 0 || exp_stat.size() > 0)
      @(posedge clk);
    repeat (4) @(posedge clk); // Catch stray outputs
    check_value("good_count", 64'(m_good), 64'(good_count));
    check_value("err_count", 64'(m_bad), 64'(err_count));
    $display("%s: %0d words, %s", name, test_words[t], errors == errs_before ? "ok" : "failed");
  endtask

  initial begin
    void'($urandom(32'heaa1_fe94));
    rst_n = 1'b0;
    crc_mode = crc_tlv_pkg::CRC_OFF;
    crc64_value = '0;
    crc32_value = '0;
    model_reset();
    test_mode = '{crc_tlv_pkg::CRC_OFF, crc_tlv_pkg::CRC_GEN, crc_tlv_pkg::CRC_CHK,
                  crc_tlv_pkg::CRC_CHK};
    for (int t = 0; t < 4; t++) begin
      test_crc64[t] = {$urandom, $urandom};
      test_crc32[t] = $urandom;
      build_test(t, t == 3);
    end
    limit = 8 * stim.size();
    run_test(0, "off mode");
    run_test(1, "generate mode");
    run_test(2, "check mode, good CRCs");
    run_test(3, "check mode, bad CRCs");
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- crc_tlv_stage.f
+incdir+bench
hdl/crc_tlv_pkg.sv
hdl/tlv_decode.sv
hdl/crc_footer_exec.sv
hdl/crc_status.sv
hdl/crc_tlv_stage.sv
bench/crc_tlv_stage_tb.sv

//--- hdl/crc_footer_exec.sv
// Execute stage of the TLV CRC stage.
// Data words go to the external CRC engine port. Footer words go to the
// output FIFO, with the CRC word generated or checked per the global
// mode and the error code patched into the last word on a failed check.
// Check results are passed on to the status block.

`default_nettype none

module crc_footer_exec (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 word_valid,
  input  logic                                 word_sot,
  input  logic                                 word_eot,
  input  crc_tlv_pkg::tlv_type_e               word_type,
  input  logic [crc_tlv_pkg::DATA_W-1:0]       word_tdata,
  input  logic [crc_tlv_pkg::STRB_W-1:0]       word_tstrb,
  input  logic [crc_tlv_pkg::WORD_NUM_W-1:0]   word_num,
  input  crc_tlv_pkg::crc_kind_e               crc_kind,
  input  crc_tlv_pkg::crc_mode_e               crc_mode,
  input  logic [crc_tlv_pkg::DATA_W-1:0]       crc64_value,
  input  logic [31:0]                          crc32_value,
  output logic                                 ob_wr,
  output logic                                 ob_sot,
  output logic                                 ob_eot,
  output crc_tlv_pkg::tlv_type_e               ob_type,
  output logic [crc_tlv_pkg::DATA_W-1:0]       ob_tdata,
  output logic                                 eng_valid,
  output logic                                 eng_init,
  output logic                                 eng_sof,
  output logic [crc_tlv_pkg::DATA_W-1:0]       eng_data,
  output logic [crc_tlv_pkg::STRB_W-1:0]       eng_vbytes,
  output logic                                 frame_checked,
  output logic                                 frame_bad
);

  logic                              data_word;
  logic                              ftr_word;
  logic                              ftr_crc;
  logic                              ftr_eot;
  logic                              gen_mode;
  logic                              chk_mode;
  logic                              crc_fail;  // Mismatch seen in current footer
  logic                              crc_mismatch;
  logic [crc_tlv_pkg::DATA_W-1:0]    crc_sel;
  logic [crc_tlv_pkg::DATA_W-1:0]    ftr_data;

  assign data_word = word_valid && (word_type == crc_tlv_pkg::TLV_DATA);
  assign ftr_word  = word_valid && (word_type == crc_tlv_pkg::TLV_FTR);
  assign ftr_crc   = ftr_word && (word_num == crc_tlv_pkg::FTR_CRC_WORD);
  assign ftr_eot   = ftr_word && word_eot;
  assign gen_mode  = (crc_mode == crc_tlv_pkg::CRC_GEN);
  assign chk_mode  = (crc_mode == crc_tlv_pkg::CRC_CHK);

  // 32-bit CRC sits in the low half, upper bits zero
  assign crc_sel = (crc_kind == crc_tlv_pkg::KIND_CRC32) ?
                   {{(crc_tlv_pkg::DATA_W-32){1'b0}}, crc32_value} : crc64_value;

  assign crc_mismatch = (word_tdata != crc_sel);

  always_comb begin
    ftr_data = word_tdata;
    if (ftr_crc && gen_mode) begin
      ftr_data = crc_sel;
    end else if (word_eot && chk_mode && crc_fail &&
                 (word_tdata[crc_tlv_pkg::ERR_CODE_W-1:0] == '0)) begin
      // Keep any error already reported upstream
      ftr_data[crc_tlv_pkg::ERR_CODE_W-1:0] = crc_tlv_pkg::CRC_ERR_CODE;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ob_wr         <= 1'b0;
      eng_valid     <= 1'b0;
      eng_init      <= 1'b0;
      eng_sof       <= 1'b0;
      frame_checked <= 1'b0;
      frame_bad     <= 1'b0;
      crc_fail      <= 1'b0;
    end else begin
      ob_wr     <= ftr_word;
      eng_valid <= data_word && !word_sot;
      eng_init  <= data_word && word_sot; // Header word only seeds the engine
      eng_sof   <= data_word &&
                   (word_num == {{(crc_tlv_pkg::WORD_NUM_W-1){1'b0}}, 1'b1});

      frame_checked <= ftr_eot && chk_mode;
      frame_bad     <= ftr_eot && chk_mode && crc_fail;

      if (ftr_eot) begin
        crc_fail <= 1'b0;
      end else if (ftr_crc && chk_mode) begin
        crc_fail <= crc_mismatch;
      end
    end
  end

  // Engine and output payload
  always_ff @(posedge clk) begin
    if (data_word) begin
      eng_data   <= word_tdata;
      eng_vbytes <= word_sot ? '0 : word_tstrb;
    end
    if (ftr_word) begin
      ob_type  <= word_type;
      ob_sot   <= word_sot;
      ob_eot   <= word_eot;
      ob_tdata <= ftr_data;
    end
  end

  // A word goes either to the engine or to the output FIFO
  a_one_sink: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(eng_valid && ob_wr)
  );

endmodule

`default_nettype wire

//--- hdl/crc_status.sv
// Check status for the TLV CRC stage.
// Turns per-frame check results into good and error strobes and keeps
// saturating counts of both.

`default_nettype none

module crc_status (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              frame_checked,
  input  logic                              frame_bad,
  output logic                              chk_good,
  output logic                              chk_err,
  output logic [crc_tlv_pkg::CNT_W-1:0]     good_count,
  output logic [crc_tlv_pkg::CNT_W-1:0]     err_count
);

  logic good_hit;
  logic err_hit;

  assign good_hit = frame_checked && !frame_bad;
  assign err_hit  = frame_checked && frame_bad;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      chk_good   <= 1'b0;
      chk_err    <= 1'b0;
      good_count <= '0;
      err_count  <= '0;
    end else begin
      chk_good <= good_hit;
      chk_err  <= err_hit;

      // Counts stick at max
      if (good_hit && (good_count != '1)) begin
        good_count <= good_count + 1'b1;
      end
      if (err_hit && (err_count != '1)) begin
        err_count <= err_count + 1'b1;
      end
    end
  end

  a_good_err_excl: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(chk_good && chk_err)
  );

endmodule

`default_nettype wire

//--- hdl/crc_tlv_pkg.sv
// Shared types and constants for the TLV CRC stream stage.
// Word types, global CRC mode, CRC kind and the fixed footer layout.
// Modules and the testbench refer to these by scoped name.

`default_nettype none

package crc_tlv_pkg;

  // TLV word type carried with every FIFO word
  typedef enum logic [2:0] {
    TLV_CMD   = 3'd0,
    TLV_DATA  = 3'd1,
    TLV_FTR   = 3'd2,
    TLV_OTHER = 3'd3
  } tlv_type_e;

  // Global CRC mode, static while traffic flows
  typedef enum logic [1:0] {
    CRC_OFF = 2'd0,
    CRC_GEN = 2'd1,
    CRC_CHK = 2'd2
  } crc_mode_e;

  // Kind selected by the last command frame
  typedef enum logic {
    KIND_CRC64 = 1'b0,
    KIND_CRC32 = 1'b1
  } crc_kind_e;

  localparam int DATA_W     = 64;
  localparam int STRB_W     = 8;
  localparam int WORD_NUM_W = 8; // Saturating word counter

  // Command word 1, bit 0 holds the kind
  localparam logic [WORD_NUM_W-1:0] CMD_KIND_WORD = 8'd1;
  localparam int                    CMD_KIND_BIT  = 0;

  // Footer layout
  localparam logic [WORD_NUM_W-1:0] FTR_CRC_WORD = 8'd5;
  localparam int                    ERR_CODE_W   = 8; // Low bits of the last footer word
  localparam logic [ERR_CODE_W-1:0] CRC_ERR_CODE = 8'h2A;

  localparam int CNT_W = 16; // Status counters

endpackage

`default_nettype wire

//--- hdl/crc_tlv_stage.sv
// TLV CRC stream stage, top level.
// Sits between an input and an output FIFO next to external CRC
// calculators. Decode, execute and status each add one register stage.

`default_nettype none

module crc_tlv_stage (
  input  logic                                 clk,
  input  logic                                 rst_n,
  // Input FIFO
  input  crc_tlv_pkg::tlv_type_e               ib_type,
  input  logic                                 ib_sot,
  input  logic                                 ib_eot,
  input  logic [crc_tlv_pkg::DATA_W-1:0]       ib_tdata,
  input  logic [crc_tlv_pkg::STRB_W-1:0]       ib_tstrb,
  input  logic                                 ib_empty,
  output logic                                 ib_rd,
  // Output FIFO
  input  logic                                 ob_afull,
  output logic                                 ob_wr,
  output crc_tlv_pkg::tlv_type_e               ob_type,
  output logic                                 ob_sot,
  output logic                                 ob_eot,
  output logic [crc_tlv_pkg::DATA_W-1:0]       ob_tdata,
  // CRC calculators
  input  logic [crc_tlv_pkg::DATA_W-1:0]       crc64_value,
  input  logic [31:0]                          crc32_value,
  input  crc_tlv_pkg::crc_mode_e               crc_mode,
  output logic                                 eng_valid,
  output logic [crc_tlv_pkg::DATA_W-1:0]       eng_data,
  output logic [crc_tlv_pkg::STRB_W-1:0]       eng_vbytes,
  output logic                                 eng_init,
  output logic                                 eng_sof,
  // Status
  output logic                                 chk_good,
  output logic                                 chk_err,
  output logic [crc_tlv_pkg::CNT_W-1:0]        good_count,
  output logic [crc_tlv_pkg::CNT_W-1:0]        err_count
);

  logic                                word_valid;
  logic                                word_sot;
  logic                                word_eot;
  crc_tlv_pkg::tlv_type_e              word_type;
  logic [crc_tlv_pkg::DATA_W-1:0]      word_tdata;
  logic [crc_tlv_pkg::STRB_W-1:0]      word_tstrb;
  logic [crc_tlv_pkg::WORD_NUM_W-1:0]  word_num;
  crc_tlv_pkg::crc_kind_e              crc_kind;
  logic                                frame_checked;
  logic                                frame_bad;

  tlv_decode u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .ib_empty   (ib_empty),
    .ob_afull   (ob_afull),
    .ib_sot     (ib_sot),
    .ib_eot     (ib_eot),
    .ib_type    (ib_type),
    .ib_tdata   (ib_tdata),
    .ib_tstrb   (ib_tstrb),
    .ib_rd      (ib_rd),
    .word_valid (word_valid),
    .word_sot   (word_sot),
    .word_eot   (word_eot),
    .word_type  (word_type),
    .word_tdata (word_tdata),
    .word_tstrb (word_tstrb),
    .word_num   (word_num),
    .crc_kind   (crc_kind)
  );

  crc_footer_exec u_exec (
    .clk           (clk),
    .rst_n         (rst_n),
    .word_valid    (word_valid),
    .word_sot      (word_sot),
    .word_eot      (word_eot),
    .word_type     (word_type),
    .word_tdata    (word_tdata),
    .word_tstrb    (word_tstrb),
    .word_num      (word_num),
    .crc_kind      (crc_kind),
    .crc_mode      (crc_mode),
    .crc64_value   (crc64_value),
    .crc32_value   (crc32_value),
    .ob_wr         (ob_wr),
    .ob_sot        (ob_sot),
    .ob_eot        (ob_eot),
    .ob_type       (ob_type),
    .ob_tdata      (ob_tdata),
    .eng_valid     (eng_valid),
    .eng_init      (eng_init),
    .eng_sof       (eng_sof),
    .eng_data      (eng_data),
    .eng_vbytes    (eng_vbytes),
    .frame_checked (frame_checked),
    .frame_bad     (frame_bad)
  );

  crc_status u_status (
    .clk           (clk),
    .rst_n         (rst_n),
    .frame_checked (frame_checked),
    .frame_bad     (frame_bad),
    .chk_good      (chk_good),
    .chk_err       (chk_err),
    .good_count    (good_count),
    .err_count     (err_count)
  );

endmodule

`default_nettype wire

//--- hdl/tlv_decode.sv
// Input side of the TLV CRC stage.
// Reads the input FIFO while the output side has room, registers each
// word with its position in the frame and captures the CRC kind from
// command frames.

`default_nettype none

module tlv_decode (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 ib_empty,
  input  logic                                 ob_afull,
  input  logic                                 ib_sot,
  input  logic                                 ib_eot,
  input  crc_tlv_pkg::tlv_type_e               ib_type,
  input  logic [crc_tlv_pkg::DATA_W-1:0]       ib_tdata,
  input  logic [crc_tlv_pkg::STRB_W-1:0]       ib_tstrb,
  output logic                                 ib_rd,
  output logic                                 word_valid,
  output logic                                 word_sot,
  output logic                                 word_eot,
  output crc_tlv_pkg::tlv_type_e               word_type,
  output logic [crc_tlv_pkg::DATA_W-1:0]       word_tdata,
  output logic [crc_tlv_pkg::STRB_W-1:0]       word_tstrb,
  output logic [crc_tlv_pkg::WORD_NUM_W-1:0]   word_num,
  output crc_tlv_pkg::crc_kind_e               crc_kind
);

  logic cmd_kind_hit;

  // Stall on output almost full, in-flight words still drain
  assign ib_rd = !ib_empty && !ob_afull;

  assign cmd_kind_hit = word_valid && (word_type == crc_tlv_pkg::TLV_CMD) &&
                        (word_num == crc_tlv_pkg::CMD_KIND_WORD);

  // Word register
  always_ff @(posedge clk) begin
    if (ib_rd) begin
      word_sot   <= ib_sot;
      word_eot   <= ib_eot;
      word_type  <= ib_type;
      word_tdata <= ib_tdata;
      word_tstrb <= ib_tstrb;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word_valid <= 1'b0;
      word_num   <= '0;
      crc_kind   <= crc_tlv_pkg::KIND_CRC64;
    end else begin
      word_valid <= ib_rd;

      // Restart at sot, hold at max for long frames
      if (ib_rd && ib_sot) begin
        word_num <= '0;
      end else if (ib_rd && (word_num != '1)) begin
        word_num <= word_num + 1'b1;
      end

      if (cmd_kind_hit) begin
        crc_kind <= crc_tlv_pkg::crc_kind_e'(word_tdata[crc_tlv_pkg::CMD_KIND_BIT]);
      end
    end
  end

  // No word may appear after a cycle with an empty input FIFO
  a_no_read_when_empty: assert property (
    @(posedge clk) disable iff (!rst_n)
    ib_empty |=> !word_valid
  );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the TLV CRC stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module crc_tlv_stage_tb \
  -f crc_tlv_stage.f -o crc_tlv_stage_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/crc_tlv_stage_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
  exit 1
fi
exit 0
